//--- design/fe_pkg.sv
package fe_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////

    localparam int XLEN = 32;
    localparam int PC_W = 32;

    // Program image, word count must be a power of two
    localparam int ROM_WORDS = 16;

    // Fetch starts here after reset
    localparam logic [PC_W-1:0] RESET_PC = 32'h0000_1000;

    //////////////////////////////////////////////////
    // Opcodes and ALU function codes
    //////////////////////////////////////////////////

    localparam logic [5:0] OP_ALU = 6'h00;
    localparam logic [5:0] OP_BR  = 6'h04;

    localparam logic [10:0] FUNC_ADD = 11'h020;
    localparam logic [10:0] FUNC_SUB = 11'h022;
    localparam logic [10:0] FUNC_AND = 11'h024;
    localparam logic [10:0] FUNC_OR  = 11'h025;

    //////////////////////////////////////////////////
    // Instruction word formats
    //////////////////////////////////////////////////

    // Register-register ALU operation
    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rd;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [10:0] func;
    } alu_fmt_t;

    // Compare-and-branch, offset counted in words from the branch pc
    typedef struct packed {
        logic [5:0]         opcode;
        logic [4:0]         rs;
        logic [4:0]         rt;
        logic signed [15:0] offset;
    } br_fmt_t;

    // Same 32 bits seen through either format
    typedef union packed {
        alu_fmt_t alu_fmt;
        br_fmt_t  br_fmt;
    } inst_word_u;

endpackage

//--- design/inst_rom.sv
module inst_rom #(
    parameter int ROM_WORDS = fe_pkg::ROM_WORDS
) (
    input  logic [fe_pkg::PC_W-1:0] pc_i,
    output fe_pkg::inst_word_u      word_o
);

    localparam int IW = $clog2(ROM_WORDS);

    logic [IW-1:0] idx;

    // Upper pc bits are dropped so fetch wraps around the image
    assign idx = pc_i[2 +: IW];

    // Program needs at least 16 words
    // Word 8 closes the loop 3..8, the last word jumps back to word 0
    always_comb begin
        word_o = '0;
        case (int'(idx))
            0: word_o.alu_fmt = '{fe_pkg::OP_ALU, 5'd1, 5'd0, 5'd0, fe_pkg::FUNC_ADD};
            1: word_o.alu_fmt = '{fe_pkg::OP_ALU, 5'd2, 5'd1, 5'd1, fe_pkg::FUNC_ADD};
            2: word_o.alu_fmt = '{fe_pkg::OP_ALU, 5'd3, 5'd2, 5'd1, fe_pkg::FUNC_SUB};
            3: word_o.alu_fmt = '{fe_pkg::OP_ALU, 5'd4, 5'd3, 5'd2, fe_pkg::FUNC_AND};
            4: word_o.alu_fmt = '{fe_pkg::OP_ALU, 5'd5, 5'd4, 5'd1, fe_pkg::FUNC_OR};
            // Forward skip, predicted not taken
            5: word_o.br_fmt = '{fe_pkg::OP_BR, 5'd5, 5'd0, 16'sd3};
            6: word_o.alu_fmt = '{fe_pkg::OP_ALU, 5'd6, 5'd5, 5'd4, fe_pkg::FUNC_ADD};
            7: word_o.alu_fmt = '{fe_pkg::OP_ALU, 5'd7, 5'd6, 5'd3, fe_pkg::FUNC_SUB};
            // Loop branch back to word 3
            8: word_o.br_fmt = '{fe_pkg::OP_BR, 5'd7, 5'd1, -16'sd5};
            ROM_WORDS - 1: begin
                word_o.br_fmt = '{fe_pkg::OP_BR, 5'd0, 5'd0, 16'(1 - ROM_WORDS)};
            end
            default: begin
                word_o.alu_fmt = '{fe_pkg::OP_ALU, 5'(idx), 5'd1, 5'd2, fe_pkg::FUNC_OR};
            end
        endcase
    end

endmodule

//--- design/fetch_unit.sv
module fetch_unit (
    input  logic                    clk,
    input  logic                    rst_n_i,

    // Pc reload from the back end
    input  logic                    redirect_i,
    input  logic [fe_pkg::PC_W-1:0] redirect_pc_i,

    // Instruction memory
    input  fe_pkg::inst_word_u      rom_word_i,
    output logic [fe_pkg::PC_W-1:0] rom_pc_o,

    // Queue write side
    input  logic                    full_i,
    output logic                    push_o,
    output logic [fe_pkg::PC_W-1:0] push_pc_o,
    output fe_pkg::inst_word_u      push_inst_o,
    output logic                    push_pred_taken_o
);

    localparam logic [fe_pkg::PC_W-1:0] PC_STEP = 4;

    logic [fe_pkg::PC_W-1:0] pc_q;
    logic [fe_pkg::PC_W-1:0] next_pc;
    logic [fe_pkg::PC_W-1:0] br_disp;
    logic                    run_q;
    logic                    is_branch;
    logic                    pred_taken;

    //////////////////////////////////////////////////
    // Pre-decode and prediction
    //////////////////////////////////////////////////

    assign is_branch = (rom_word_i.br_fmt.opcode == fe_pkg::OP_BR);

    // Backward means taken, everything else falls through
    assign pred_taken = is_branch && rom_word_i.br_fmt.offset[15];

    // Word offset to byte displacement
    assign br_disp = {{(fe_pkg::PC_W - 18){rom_word_i.br_fmt.offset[15]}},
                      rom_word_i.br_fmt.offset, 2'b00};

    assign next_pc = pred_taken ? (pc_q + br_disp) : (pc_q + PC_STEP);

    //////////////////////////////////////////////////
    // Queue push
    //////////////////////////////////////////////////

    assign rom_pc_o = pc_q;

    // No push on the redirect cycle, the queue is being emptied
    assign push_o            = run_q && !full_i && !redirect_i;
    assign push_pc_o         = pc_q;
    assign push_inst_o       = rom_word_i;
    assign push_pred_taken_o = pred_taken;

    //////////////////////////////////////////////////
    // Pc register
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q  <= fe_pkg::RESET_PC;
            run_q <= 1'b0;
        end else begin
            // Fetch begins the cycle after reset is released
            run_q <= 1'b1;
            if (redirect_i) begin
                pc_q <= redirect_pc_i;
            end else if (push_o) begin
                pc_q <= next_pc;
            end
            // Otherwise stalled on full, hold the pc
        end
    end

endmodule

//--- design/inst_queue.sv
module inst_queue #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    flush_i,

    // Write side, one entry per cycle
    input  logic                    push_i,
    input  logic [fe_pkg::PC_W-1:0] push_pc_i,
    input  logic [fe_pkg::XLEN-1:0] push_inst_i,
    input  logic                    push_pred_i,
    output logic                    full_o,

    // Read side, up to two entries per cycle
    input  logic                    pop_one_i,
    input  logic                    pop_two_i,
    output logic [1:0]              count_o,
    output logic [fe_pkg::PC_W-1:0] head0_pc_o,
    output logic [fe_pkg::XLEN-1:0] head0_inst_o,
    output logic                    head0_pred_o,
    output logic [fe_pkg::PC_W-1:0] head1_pc_o,
    output logic [fe_pkg::XLEN-1:0] head1_inst_o,
    output logic                    head1_pred_o
);

    // Depth is a power of two, at least 2, so the pointers wrap by themselves
    localparam int AW = $clog2(QUEUE_DEPTH);
    localparam logic [AW:0] FULL_LEVEL = (AW + 1)'(QUEUE_DEPTH);
    localparam logic [AW:0] PAIR_LEVEL = (AW + 1)'(2);

    logic [fe_pkg::PC_W-1:0] pc_mem   [QUEUE_DEPTH];
    logic [fe_pkg::XLEN-1:0] inst_mem [QUEUE_DEPTH];
    logic                    pred_mem [QUEUE_DEPTH];

    logic [AW-1:0] head_q;
    logic [AW-1:0] head1_idx;
    logic [AW-1:0] tail_q;
    logic [AW:0]   occ_q;
    logic          push_ok;
    logic [1:0]    pop_num;

    assign full_o  = (occ_q == FULL_LEVEL);
    assign push_ok = push_i && !full_o;

    always_comb begin
        if (pop_two_i) begin
            pop_num = 2'd2;
        end else if (pop_one_i) begin
            pop_num = 2'd1;
        end else begin
            pop_num = 2'd0;
        end
    end

    // Reported level saturates at two
    // A flushing queue shows nothing so no stale entry gets popped
    always_comb begin
        if (flush_i) begin
            count_o = 2'd0;
        end else if (occ_q >= PAIR_LEVEL) begin
            count_o = 2'd2;
        end else begin
            count_o = occ_q[1:0];
        end
    end

    //////////////////////////////////////////////////
    // Head entries
    //////////////////////////////////////////////////

    assign head1_idx = head_q + 1'b1;

    assign head0_pc_o   = pc_mem[head_q];
    assign head0_inst_o = inst_mem[head_q];
    assign head0_pred_o = pred_mem[head_q];
    assign head1_pc_o   = pc_mem[head1_idx];
    assign head1_inst_o = inst_mem[head1_idx];
    assign head1_pred_o = pred_mem[head1_idx];

    //////////////////////////////////////////////////
    // Storage and pointers
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (push_ok) begin
            pc_mem[tail_q]   <= push_pc_i;
            inst_mem[tail_q] <= push_inst_i;
            pred_mem[tail_q] <= push_pred_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            head_q <= '0;
            tail_q <= '0;
            occ_q  <= '0;
        end else if (flush_i) begin
            head_q <= '0;
            tail_q <= '0;
            occ_q  <= '0;
        end else begin
            if (push_ok) begin
                tail_q <= tail_q + 1'b1;
            end
            head_q <= head_q + AW'(pop_num);
            occ_q  <= occ_q + (AW + 1)'(push_ok) - (AW + 1)'(pop_num);
        end
    end

endmodule

//--- design/issue_stage.sv
module issue_stage (
    input  logic                    clk,
    input  logic                    rst_n_i,

    // Queue read side
    input  logic [1:0]              count_i,
    input  logic [fe_pkg::PC_W-1:0] head0_pc_i,
    input  fe_pkg::inst_word_u      head0_inst_i,
    input  logic                    head0_pred_i,
    input  logic [fe_pkg::PC_W-1:0] head1_pc_i,
    input  fe_pkg::inst_word_u      head1_inst_i,
    input  logic                    head1_pred_i,
    output logic                    pop_one_o,
    output logic                    pop_two_o,

    // Four-phase issue port
    output logic                    issue_req_o,
    input  logic                    issue_ack_i,
    output logic [fe_pkg::PC_W-1:0] slot0_pc_o,
    output fe_pkg::inst_word_u      slot0_inst_o,
    output logic                    slot0_pred_o,
    output logic                    slot0_is_branch_o,
    output logic [fe_pkg::PC_W-1:0] slot1_pc_o,
    output fe_pkg::inst_word_u      slot1_inst_o,
    output logic                    slot1_pred_o,
    output logic                    slot1_is_branch_o,
    output logic                    slot1_valid_o
);

    localparam logic [1:0] S_IDLE    = 2'd0;
    localparam logic [1:0] S_REQ     = 2'd1;
    localparam logic [1:0] S_ACK_LOW = 2'd2;

    logic [1:0] state_q;
    logic [1:0] state_d;
    logic       take;

    function automatic logic word_is_branch(fe_pkg::inst_word_u w);
        return (w.br_fmt.opcode == fe_pkg::OP_BR);
    endfunction

    // Pick up work only with ack low, so req never rises over a high ack
    assign take      = (state_q == S_IDLE) && (count_i != 2'd0) && !issue_ack_i;
    assign pop_one_o = take && (count_i == 2'd1);
    assign pop_two_o = take && count_i[1];

    assign issue_req_o = (state_q == S_REQ);

    assign slot0_is_branch_o = word_is_branch(slot0_inst_o);
    assign slot1_is_branch_o = word_is_branch(slot1_inst_o);

    //////////////////////////////////////////////////
    // Handshake FSM
    //////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (take) begin
                    state_d = S_REQ;
                end
            end
            S_REQ: begin
                if (issue_ack_i) begin
                    state_d = S_ACK_LOW;
                end
            end
            S_ACK_LOW: begin
                if (!issue_ack_i) begin
                    state_d = S_IDLE;
                end
            end
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q       <= S_IDLE;
            slot1_valid_o <= 1'b0;
        end else begin
            state_q <= state_d;
            if (take) begin
                slot1_valid_o <= count_i[1];
            end
        end
    end

    // Slot data is held from the pop until the next pop
    always_ff @(posedge clk) begin
        if (take) begin
            slot0_pc_o   <= head0_pc_i;
            slot0_inst_o <= head0_inst_i;
            slot0_pred_o <= head0_pred_i;
            slot1_pc_o   <= head1_pc_i;
            slot1_inst_o <= head1_inst_i;
            slot1_pred_o <= head1_pred_i;
        end
    end

endmodule

//--- design/fe_top.sv
module fe_top #(
    parameter int QUEUE_DEPTH = 8,
    parameter int ROM_WORDS   = fe_pkg::ROM_WORDS
) (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    redirect_i,
    input  logic [fe_pkg::PC_W-1:0] redirect_pc_i,
    input  logic                    issue_ack_i,
    output logic                    issue_req_o,
    output logic [fe_pkg::PC_W-1:0] slot0_pc_o,
    output fe_pkg::inst_word_u      slot0_inst_o,
    output logic                    slot0_pred_o,
    output logic                    slot0_is_branch_o,
    output logic [fe_pkg::PC_W-1:0] slot1_pc_o,
    output fe_pkg::inst_word_u      slot1_inst_o,
    output logic                    slot1_pred_o,
    output logic                    slot1_is_branch_o,
    output logic                    slot1_valid_o
);

    // Fetch side
    logic [fe_pkg::PC_W-1:0] rom_pc;
    fe_pkg::inst_word_u      rom_word;
    logic                    push;
    logic [fe_pkg::PC_W-1:0] push_pc;
    fe_pkg::inst_word_u      push_inst;
    logic                    push_pred_taken;
    logic                    full;

    // Issue side
    logic [1:0]              count;
    logic [fe_pkg::PC_W-1:0] head0_pc;
    logic [fe_pkg::XLEN-1:0] head0_inst;
    logic                    head0_pred;
    logic [fe_pkg::PC_W-1:0] head1_pc;
    logic [fe_pkg::XLEN-1:0] head1_inst;
    logic                    head1_pred;
    logic                    pop_one;
    logic                    pop_two;

    inst_rom #(
        .ROM_WORDS(ROM_WORDS)
    ) u_rom (
        .pc_i  (rom_pc),
        .word_o(rom_word)
    );

    fetch_unit u_fetch (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .redirect_i       (redirect_i),
        .redirect_pc_i    (redirect_pc_i),
        .rom_word_i       (rom_word),
        .rom_pc_o         (rom_pc),
        .full_i           (full),
        .push_o           (push),
        .push_pc_o        (push_pc),
        .push_inst_o      (push_inst),
        .push_pred_taken_o(push_pred_taken)
    );

    // Redirect also empties the queue
    inst_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_queue (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .flush_i     (redirect_i),
        .push_i      (push),
        .push_pc_i   (push_pc),
        .push_inst_i (push_inst),
        .push_pred_i (push_pred_taken),
        .full_o      (full),
        .pop_one_i   (pop_one),
        .pop_two_i   (pop_two),
        .count_o     (count),
        .head0_pc_o  (head0_pc),
        .head0_inst_o(head0_inst),
        .head0_pred_o(head0_pred),
        .head1_pc_o  (head1_pc),
        .head1_inst_o(head1_inst),
        .head1_pred_o(head1_pred)
    );

    issue_stage u_issue (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .count_i          (count),
        .head0_pc_i       (head0_pc),
        .head0_inst_i     (head0_inst),
        .head0_pred_i     (head0_pred),
        .head1_pc_i       (head1_pc),
        .head1_inst_i     (head1_inst),
        .head1_pred_i     (head1_pred),
        .pop_one_o        (pop_one),
        .pop_two_o        (pop_two),
        .issue_req_o      (issue_req_o),
        .issue_ack_i      (issue_ack_i),
        .slot0_pc_o       (slot0_pc_o),
        .slot0_inst_o     (slot0_inst_o),
        .slot0_pred_o     (slot0_pred_o),
        .slot0_is_branch_o(slot0_is_branch_o),
        .slot1_pc_o       (slot1_pc_o),
        .slot1_inst_o     (slot1_inst_o),
        .slot1_pred_o     (slot1_pred_o),
        .slot1_is_branch_o(slot1_is_branch_o),
        .slot1_valid_o    (slot1_valid_o)
    );

endmodule

//--- testbench/fe_asserts.sv
module fe_asserts (
    input logic                    clk,
    input logic                    rst_n_i,
    input logic                    redirect_i,
    input logic [fe_pkg::PC_W-1:0] redirect_pc_i,
    input logic                    ack_i,
    input logic                    req_i,
    input logic [fe_pkg::PC_W-1:0] s0_pc_i,
    input logic [fe_pkg::XLEN-1:0] s0_inst_i,
    input logic                    s0_pred_i,
    input logic                    s0_br_i,
    input logic [fe_pkg::PC_W-1:0] s1_pc_i,
    input logic [fe_pkg::XLEN-1:0] s1_inst_i,
    input logic                    s1_pred_i,
    input logic                    s1_br_i,
    input logic                    s1_valid_i,
    input logic                    pop_one_i,
    input logic                    pop_two_i,
    input logic                    full_i,
    input logic [fe_pkg::PC_W-1:0] fetch_pc_i
);

    timeunit 1ns;
    timeprecision 100ps;

    // Raised by any failing assertion below
    logic failed = 1'b0;

    logic                    req_q;
    logic [fe_pkg::PC_W-1:0] exp_pc;
    logic [fe_pkg::PC_W-1:0] prev_fetch_pc;
    logic [fe_pkg::PC_W-1:0] prev_s0_pc;
    logic [fe_pkg::PC_W-1:0] prev_s1_pc;
    logic [fe_pkg::XLEN-1:0] prev_s0_inst;
    logic [fe_pkg::XLEN-1:0] prev_s1_inst;
    logic                    prev_s1_valid;

    function automatic logic branch_word(input logic [fe_pkg::XLEN-1:0] inst);
        return inst[31:26] == fe_pkg::OP_BR;
    endfunction

    // Backward branches jump by their word offset, everything else steps one word
    function automatic logic [fe_pkg::PC_W-1:0] follow_pc(
        input logic [fe_pkg::PC_W-1:0] pc,
        input logic [fe_pkg::XLEN-1:0] inst
    );
        int offset;
        offset = int'($signed(inst[15:0]));
        if (branch_word(inst) && offset < 0) begin
            return pc + offset * 4;
        end
        return pc + 32'd4;
    endfunction

    //////////////////////////////////////////////////
    // Reference pc of the next issued slot
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        prev_fetch_pc <= fetch_pc_i;
        prev_s0_pc    <= s0_pc_i;
        prev_s1_pc    <= s1_pc_i;
        prev_s0_inst  <= s0_inst_i;
        prev_s1_inst  <= s1_inst_i;
        prev_s1_valid <= s1_valid_i;
        if (!rst_n_i) begin
            req_q  <= 1'b0;
            exp_pc <= fe_pkg::RESET_PC;
        end else begin
            req_q <= req_i;
            if (req_i && !req_q) begin
                exp_pc <= s1_valid_i ? follow_pc(s1_pc_i, s1_inst_i)
                                     : follow_pc(s0_pc_i, s0_inst_i);
            end
            // Flush edge, whatever rises after this is new path
            if (redirect_i) begin
                exp_pc <= redirect_pc_i;
            end
        end
    end

    //////////////////////////////////////////////////
    // Reset state
    //////////////////////////////////////////////////

    assert property (@(posedge clk) !rst_n_i |=> !req_i)
        else begin
            failed = 1'b1;
            $error("CHECK FAILED t=%0t issue_req_o got %b expected 0 after reset",
                   $time, $sampled(req_i));
        end

    assert property (@(posedge clk) !rst_n_i |=> fetch_pc_i == fe_pkg::RESET_PC)
        else begin
            failed = 1'b1;
            $error("CHECK FAILED t=%0t rom_pc got %h expected %h",
                   $time, $sampled(fetch_pc_i), fe_pkg::RESET_PC);
        end

    //////////////////////////////////////////////////
    // Four-phase handshake
    //////////////////////////////////////////////////

    assert property (@(posedge clk) disable iff (!rst_n_i)
                     $rose(req_i) |-> $past(pop_one_i || pop_two_i))
        else begin
            failed = 1'b1;
            $error("CHECK FAILED t=%0t issue_req_o rose without a queue pop", $time);
        end

    assert property (@(posedge clk) disable iff (!rst_n_i) $rose(req_i) |-> !$past(ack_i))
        else begin
            failed = 1'b1;
            $error("CHECK FAILED t=%0t issue_ack_i got 1 expected 0 when issue_req_o rose",
                   $time);
        end

    assert property (@(posedge clk) disable iff (!rst_n_i) $fell(req_i) |-> $past(ack_i))
        else begin
            failed = 1'b1;
            $error("CHECK FAILED t=%0t issue_ack_i got 0 expected 1 when issue_req_o fell",
                   $time);
        end

    // Slot data held for the whole request
    assert property (@(posedge clk) disable iff (!rst_n_i)
                     req_i && req_q |-> s0_pc_i == prev_s0_pc)
        else begin
            failed = 1'b1;
            $error("CHECK FAILED t=%0t slot0_pc_o got %h expected %h",
                   $time, $sampled(s0_pc_i), $sampled(prev_s0_pc));
        end

    assert property (@(posedge clk) disable iff (!rst_n_i)
                     req_i && req_q |-> s0_inst_i == prev_s0_inst)
        else begin
            failed = 1'b1;
            $error("CHECK FAILED t=%0t slot0_inst_o got %h expected %h",
                   $time, $sampled(s0_inst_i), $sampled(prev_s0_inst));
        end

    assert property (@(posedge clk) disable iff (!rst_n_i)
                     req_i && req_q |-> s1_pc_i == prev_s1_pc)
        else begin
            failed = 1'b1;
            $error("CHECK FAILED t=%0t slot1_pc_o got %h expected %h",
                   $time, $sampled(s1_pc_i), $sampled(prev_s1_pc));
        end

    assert property (@(posedge clk) disable iff (!rst_n_i)
                     req_i && req_q |-> s1_inst_i == prev_s1_inst)
        else begin
            failed = 1'b1;
            $error("CHECK FAILED t=%0t slot1_inst_o got %h expected %h",
                   $time, $sampled(s1_inst_i), $sampled(prev_s1_inst));
        end

    assert property (@(posedge clk) disable iff (!rst_n_i)
                     req_i && req_q |-> s1_valid_i == prev_s1_valid)
        else begin
            failed = 1'b1;
            $error("CHECK FAILED t=%0t slot1_valid_o got %b expected %b",
                   $time, $sampled(s1_valid_i), $sampled(prev_s1_valid));
        end

    //////////////////////////////////////////////////
    // Program order and pre-decode
    //////////////////////////////////////////////////

    assert property (@(posedge clk) disable iff (!rst_n_i) $rose(req_i) |-> s0_pc_i == exp_pc)
        else begin
            failed = 1'b1;
            $error("CHECK FAILED t=%0t slot0_pc_o got %h expected %h",
                   $time, $sampled(s0_pc_i), $sampled(exp_pc));
        end

    assert property (@(posedge clk) disable iff (!rst_n_i)
                     $rose(req_i) && s1_valid_i |-> s1_pc_i == follow_pc(s0_pc_i, s0_inst_i))
        else begin
            failed = 1'b1;
            $error("CHECK FAILED t=%0t slot1_pc_o got %h expected %h", $time,
                   $sampled(s1_pc_i), follow_pc($sampled(s0_pc_i), $sampled(s0_inst_i)));
        end

    assert property (@(posedge clk) disable iff (!rst_n_i)
                     req_i |-> s0_br_i == branch_word(s0_inst_i)
                               && s0_pred_i == (branch_word(s0_inst_i) && s0_inst_i[15]))
        else begin
            failed = 1'b1;
            $error("CHECK FAILED t=%0t slot0_is_branch_o/slot0_pred_o got %b/%b expected %b/%b",
                   $time, $sampled(s0_br_i), $sampled(s0_pred_i),
                   branch_word($sampled(s0_inst_i)),
                   branch_word($sampled(s0_inst_i)) && $sampled(s0_inst_i[15]));
        end

    assert property (@(posedge clk) disable iff (!rst_n_i)
                     req_i && s1_valid_i |-> s1_br_i == branch_word(s1_inst_i)
                               && s1_pred_i == (branch_word(s1_inst_i) && s1_inst_i[15]))
        else begin
            failed = 1'b1;
            $error("CHECK FAILED t=%0t slot1_is_branch_o/slot1_pred_o got %b/%b expected %b/%b",
                   $time, $sampled(s1_br_i), $sampled(s1_pred_i),
                   branch_word($sampled(s1_inst_i)),
                   branch_word($sampled(s1_inst_i)) && $sampled(s1_inst_i[15]));
        end

    // Fetch stalls on a full queue
    assert property (@(posedge clk) disable iff (!rst_n_i)
                     full_i && !redirect_i |=> fetch_pc_i == prev_fetch_pc)
        else begin
            failed = 1'b1;
            $error("CHECK FAILED t=%0t rom_pc got %h expected %h while full",
                   $time, $sampled(fetch_pc_i), $sampled(prev_fetch_pc));
        end

endmodule

bind fe_top fe_asserts u_asserts (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .redirect_i   (redirect_i),
    .redirect_pc_i(redirect_pc_i),
    .ack_i        (issue_ack_i),
    .req_i        (issue_req_o),
    .s0_pc_i      (slot0_pc_o),
    .s0_inst_i    (slot0_inst_o),
    .s0_pred_i    (slot0_pred_o),
    .s0_br_i      (slot0_is_branch_o),
    .s1_pc_i      (slot1_pc_o),
    .s1_inst_i    (slot1_inst_o),
    .s1_pred_i    (slot1_pred_o),
    .s1_br_i      (slot1_is_branch_o),
    .s1_valid_i   (slot1_valid_o),
    .pop_one_i    (pop_one),
    .pop_two_i    (pop_two),
    .full_i       (full),
    .fetch_pc_i   (rom_pc)
);

//--- testbench/fe_tb.sv
module fe_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_HANDSHAKES       = 40;
    localparam int CYCLES_PER_HANDSHAKE = 20;
    localparam int RESET_CYCLES         = 2;
    localparam int CYCLE_LIMIT          = NUM_HANDSHAKES * CYCLES_PER_HANDSHAKE + RESET_CYCLES;
    localparam int SLOW_DELAY           = 12;
    localparam logic [7:0] LFSR_SEED    = 8'd12;

    localparam logic [fe_pkg::PC_W-1:0] REDIRECT_SKIP = fe_pkg::RESET_PC + 32'd8;
    // Word 8 holds the loop branch
    localparam logic [fe_pkg::PC_W-1:0] REDIRECT_LOOP = fe_pkg::RESET_PC + 32'd32;

    logic                    clk = 1'b0;
    logic                    rst_n_i;
    logic                    redirect_i;
    logic [fe_pkg::PC_W-1:0] redirect_pc_i;
    logic                    issue_ack_i;
    logic                    issue_req_o;
    logic [fe_pkg::PC_W-1:0] slot0_pc_o;
    fe_pkg::inst_word_u      slot0_inst_o;
    logic                    slot0_pred_o;
    logic                    slot0_is_branch_o;
    logic [fe_pkg::PC_W-1:0] slot1_pc_o;
    fe_pkg::inst_word_u      slot1_inst_o;
    logic                    slot1_pred_o;
    logic                    slot1_is_branch_o;
    logic                    slot1_valid_o;

    logic       slow_ack;
    logic [7:0] lfsr = LFSR_SEED;
    int         handshakes = 0;

    always #2 clk = ~clk;

    fe_top #(
        .QUEUE_DEPTH(8),
        .ROM_WORDS  (fe_pkg::ROM_WORDS)
    ) dut0 (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .redirect_i       (redirect_i),
        .redirect_pc_i    (redirect_pc_i),
        .issue_ack_i      (issue_ack_i),
        .issue_req_o      (issue_req_o),
        .slot0_pc_o       (slot0_pc_o),
        .slot0_inst_o     (slot0_inst_o),
        .slot0_pred_o     (slot0_pred_o),
        .slot0_is_branch_o(slot0_is_branch_o),
        .slot1_pc_o       (slot1_pc_o),
        .slot1_inst_o     (slot1_inst_o),
        .slot1_pred_o     (slot1_pred_o),
        .slot1_is_branch_o(slot1_is_branch_o),
        .slot1_valid_o    (slot1_valid_o)
    );

    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
    endfunction

    // One LFSR step per bit
    task automatic draw_bits(input int n, output int value);
        int i;
        value = 0;
        for (i = 0; i < n; i++) begin
            lfsr  = lfsr_step(lfsr);
            value = value * 2 + int'(lfsr[0]);
        end
    endtask

    task automatic wait_handshakes(input int n);
        while (handshakes < n) begin
            @(posedge clk);
        end
    endtask

    task automatic send_redirect(input logic [fe_pkg::PC_W-1:0] pc);
        @(posedge clk);
        redirect_i    <= 1'b1;
        redirect_pc_i <= pc;
        @(posedge clk);
        redirect_i    <= 1'b0;
    endtask

    task automatic end_in_failure(input string why);
        $display("FAIL: see errors above");
        $fatal(1, "%s", why);
    endtask

    //////////////////////////////////////////////////
    // Back end, acknowledges each request
    //////////////////////////////////////////////////

    initial begin : back_end
        int delay;
        issue_ack_i = 1'b0;
        forever begin
            @(posedge clk);
            if (rst_n_i && issue_req_o && !issue_ack_i) begin
                if (slow_ack) begin
                    delay = SLOW_DELAY;
                end else begin
                    draw_bits(2, delay);
                end
                repeat (delay) @(posedge clk);
                issue_ack_i <= 1'b1;
                // Hold ack until req is withdrawn
                @(posedge clk);
                while (issue_req_o) begin
                    @(posedge clk);
                end
                issue_ack_i <= 1'b0;
                handshakes  <= handshakes + 1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    initial begin
        rst_n_i       = 1'b0;
        redirect_i    = 1'b0;
        redirect_pc_i = '0;
        slow_ack      = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n_i <= 1'b1;

        wait_handshakes(8);
        send_redirect(REDIRECT_SKIP);

        // Slow back end lets the queue fill up
        wait_handshakes(16);
        slow_ack <= 1'b1;
        wait_handshakes(20);
        send_redirect(REDIRECT_LOOP);
        wait_handshakes(26);
        slow_ack <= 1'b0;

        wait_handshakes(NUM_HANDSHAKES);
        @(negedge clk);
        if (dut0.u_asserts.failed) begin
            end_in_failure("an assertion in fe_asserts failed");
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

    // Stops at the first assertion failure or when the run takes too long
    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (!dut0.u_asserts.failed && cycles < CYCLE_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (dut0.u_asserts.failed) begin
            end_in_failure("an assertion in fe_asserts failed");
        end else begin
            end_in_failure($sformatf("timeout after %0d cycles with %0d of %0d handshakes done",
                                     cycles, handshakes, NUM_HANDSHAKES));
        end
    end

endmodule

//--- build.f
design/fe_pkg.sv
design/inst_rom.sv
design/fetch_unit.sv
design/inst_queue.sv
design/issue_stage.sv
design/fe_top.sv
testbench/fe_asserts.sv
testbench/fe_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing --timescale 1ns/100ps \
    --top-module fe_tb -Mdir obj_dir -f build.f

# Exit status is nonzero when the testbench ends in $fatal
./obj_dir/Vfe_tb +verilator+error+limit+100
